// File: rtl/gomoku_pkg.sv
// gomoku search definitions
package gomoku_pkg;

    localparam int BOARD_N  = 15;
    localparam int CELLS    = 225;
    localparam int LEVELS   = 5;
    localparam int MAX_CAND = 4;

    // line directions as row and column steps
    localparam int DIR_DR [4] = '{0, 1, 1, 1};
    localparam int DIR_DC [4] = '{1, 0, 1, -1};

    typedef logic [1:0]           cell_t;
    typedef logic [2*CELLS-1:0]   board_t;
    typedef logic [2*BOARD_N-1:0] row_t;
    typedef logic [7:0]           coord_t;
    typedef logic [2:0]           cand_cnt_t;
    typedef logic [2:0]           level_t;
    // byte offsets, status sits just above the 6-bit range
    typedef logic [6:0]           axi_addr_t;
    typedef logic [31:0]          axi_data_t;

    localparam cell_t CELL_EMPTY = 2'd0;
    localparam cell_t CELL_BLACK = 2'd1;
    localparam cell_t CELL_WHITE = 2'd2;

    typedef struct packed {
        logic   valid;
        logic   side;
        board_t board;
    } scan_req_t;

    typedef struct packed {
        logic                     done;
        logic                     win;
        cand_cnt_t                count;
        coord_t [MAX_CAND-1:0]    cand;
    } scan_rsp_t;

    typedef struct packed {
        logic   start;
        board_t board;
    } node_down_t;

    typedef struct packed {
        logic done;
        logic win;
    } node_up_t;

    localparam axi_addr_t REG_ROW0   = 7'h00;
    localparam axi_addr_t REG_CTRL   = 7'h3C;
    localparam axi_addr_t REG_STATUS = 7'h40;

    typedef enum logic [1:0] {
        NODE_IDLE,
        NODE_SCAN,
        NODE_NEXT,
        NODE_WAIT_CHILD
    } node_state_e;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_RUN,
        SCAN_DONE
    } scan_state_e;

endpackage

// File: rtl/threat_scan.sv
// board threat scanner
`timescale 1ns/1ps
module threat_scan (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  gomoku_pkg::scan_req_t i_req,
    output gomoku_pkg::scan_rsp_t o_rsp
);

    gomoku_pkg::scan_state_e                        state_q;
    gomoku_pkg::board_t                             board_q;
    logic                                           side_q;
    gomoku_pkg::coord_t                             idx_q;
    logic [3:0]                                     row_q;
    logic [3:0]                                     col_q;
    logic                                           win_q;
    gomoku_pkg::cand_cnt_t                          cnt_q;
    gomoku_pkg::coord_t [gomoku_pkg::MAX_CAND-1:0]  cand_q;

    logic [3:0] blk_len [4];
    logic [3:0] wht_len [4];
    logic       empty;
    logic       blk_five;
    logic       blk_four;
    logic       wht_five;
    logic       hit_win;
    logic       hit_cand;
    logic       keep;

    // stones of one color next to (r,c), walking one way
    function automatic logic [3:0] run_len(input gomoku_pkg::board_t b, input int r,
                                           input int c, input int dr, input int dc,
                                           input gomoku_pkg::cell_t color);
        logic [3:0] n;
        logic       go;
        int         rr;
        int         cc;
        n  = '0;
        go = 1'b1;
        for (int s = 1; s <= 4; s++) begin
            rr = r + s * dr;
            cc = c + s * dc;
            if (go && rr >= 0 && rr < gomoku_pkg::BOARD_N && cc >= 0 &&
                cc < gomoku_pkg::BOARD_N &&
                b[2*(rr*gomoku_pkg::BOARD_N+cc) +: 2] == color) begin
                n = n + 4'd1;
            end else begin
                go = 1'b0;
            end
        end
        return n;
    endfunction

    always_comb begin
        for (int d = 0; d < 4; d++) begin
            blk_len[d] = 4'd1
                + run_len(board_q, row_q, col_q, gomoku_pkg::DIR_DR[d],
                          gomoku_pkg::DIR_DC[d], gomoku_pkg::CELL_BLACK)
                + run_len(board_q, row_q, col_q, -gomoku_pkg::DIR_DR[d],
                          -gomoku_pkg::DIR_DC[d], gomoku_pkg::CELL_BLACK);
            wht_len[d] = 4'd1
                + run_len(board_q, row_q, col_q, gomoku_pkg::DIR_DR[d],
                          gomoku_pkg::DIR_DC[d], gomoku_pkg::CELL_WHITE)
                + run_len(board_q, row_q, col_q, -gomoku_pkg::DIR_DR[d],
                          -gomoku_pkg::DIR_DC[d], gomoku_pkg::CELL_WHITE);
        end
        blk_five = 1'b0;
        blk_four = 1'b0;
        wht_five = 1'b0;
        for (int d = 0; d < 4; d++) begin
            blk_five = blk_five | (blk_len[d] >= 4'd5);
            blk_four = blk_four | (blk_len[d] == 4'd4);
            wht_five = wht_five | (wht_len[d] >= 4'd5);
        end
    end

    assign empty    = board_q[{idx_q, 1'b0} +: 2] == gomoku_pkg::CELL_EMPTY;
    // defender candidates are the attacker's own completion cells
    assign hit_win  = empty & (side_q ? blk_five : wht_five);
    assign hit_cand = empty & (side_q ? blk_four : blk_five);
    assign keep     = (state_q == gomoku_pkg::SCAN_RUN) && hit_cand &&
                      (cnt_q < gomoku_pkg::cand_cnt_t'(gomoku_pkg::MAX_CAND));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= gomoku_pkg::SCAN_IDLE;
            idx_q   <= '0;
            row_q   <= '0;
            col_q   <= '0;
            win_q   <= 1'b0;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                gomoku_pkg::SCAN_IDLE: begin
                    if (i_req.valid) begin
                        state_q <= gomoku_pkg::SCAN_RUN;
                        idx_q   <= '0;
                        row_q   <= '0;
                        col_q   <= '0;
                        win_q   <= 1'b0;
                        cnt_q   <= '0;
                    end
                end
                gomoku_pkg::SCAN_RUN: begin
                    if (hit_win) begin
                        win_q <= 1'b1;
                    end
                    if (keep) begin
                        cnt_q <= cnt_q + 3'd1;
                    end
                    if (idx_q == gomoku_pkg::coord_t'(gomoku_pkg::CELLS - 1)) begin
                        state_q <= gomoku_pkg::SCAN_DONE;
                    end
                    idx_q <= idx_q + 8'd1;
                    if (col_q == 4'(gomoku_pkg::BOARD_N - 1)) begin
                        col_q <= '0;
                        row_q <= row_q + 4'd1;
                    end else begin
                        col_q <= col_q + 4'd1;
                    end
                end
                default: state_q <= gomoku_pkg::SCAN_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == gomoku_pkg::SCAN_IDLE && i_req.valid) begin
            board_q <= i_req.board;
            side_q  <= i_req.side;
        end
        if (keep) begin
            cand_q[cnt_q] <= idx_q;
        end
    end

    assign o_rsp.done  = state_q == gomoku_pkg::SCAN_DONE;
    assign o_rsp.win   = win_q;
    assign o_rsp.count = cnt_q;
    assign o_rsp.cand  = cand_q;

endmodule

// File: rtl/scan_arbiter.sv
// scanner arbiter
`timescale 1ns/1ps
module scan_arbiter (
    input  logic                                        i_clk,
    input  logic                                        i_rst_n,
    input  gomoku_pkg::scan_req_t [gomoku_pkg::LEVELS-1:0] i_req,
    output gomoku_pkg::scan_rsp_t [gomoku_pkg::LEVELS-1:0] o_rsp,
    output gomoku_pkg::scan_req_t                       o_scan_req,
    input  gomoku_pkg::scan_rsp_t                       i_scan_rsp
);

    logic                busy_q;
    gomoku_pkg::level_t  grant_q;
    gomoku_pkg::level_t  pick;
    logic                any_req;

    // lowest index wins
    always_comb begin
        pick    = '0;
        any_req = 1'b0;
        for (int k = gomoku_pkg::LEVELS - 1; k >= 0; k--) begin
            if (i_req[k].valid) begin
                pick    = gomoku_pkg::level_t'(k);
                any_req = 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_q  <= 1'b0;
            grant_q <= '0;
        end else if (!busy_q && any_req) begin
            busy_q  <= 1'b1;
            grant_q <= pick;
        end else if (busy_q && i_scan_rsp.done) begin
            busy_q <= 1'b0;
        end
    end

    always_comb begin
        o_scan_req       = i_req[grant_q];
        o_scan_req.valid = busy_q & i_req[grant_q].valid;
        for (int k = 0; k < gomoku_pkg::LEVELS; k++) begin
            o_rsp[k]      = i_scan_rsp;
            o_rsp[k].done = busy_q && (grant_q == gomoku_pkg::level_t'(k)) && i_scan_rsp.done;
        end
    end

endmodule

// File: rtl/kill_node.sv
// one search ply
`timescale 1ns/1ps
module kill_node (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_side,
    input  logic                   i_last,
    input  gomoku_pkg::node_down_t i_down,
    output gomoku_pkg::node_up_t   o_up,
    output gomoku_pkg::node_down_t o_child,
    input  gomoku_pkg::node_up_t   i_child,
    output gomoku_pkg::scan_req_t  o_scan,
    input  gomoku_pkg::scan_rsp_t  i_scan
);

    gomoku_pkg::node_state_e                        state_q;
    gomoku_pkg::board_t                             board_q;
    gomoku_pkg::board_t                             child_board_q;
    gomoku_pkg::coord_t [gomoku_pkg::MAX_CAND-1:0]  cand_q;
    gomoku_pkg::cand_cnt_t                          cnt_q;
    gomoku_pkg::cand_cnt_t                          ptr_q;
    gomoku_pkg::cell_t                              stone;
    logic                                           req_q;
    logic                                           child_start_q;
    logic                                           up_done_q;
    logic                                           up_win_q;
    logic                                           place;

    assign stone = i_side ? gomoku_pkg::CELL_BLACK : gomoku_pkg::CELL_WHITE;
    assign place = (state_q == gomoku_pkg::NODE_NEXT) && (ptr_q != cnt_q);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q       <= gomoku_pkg::NODE_IDLE;
            req_q         <= 1'b0;
            child_start_q <= 1'b0;
            up_done_q     <= 1'b0;
            up_win_q      <= 1'b0;
            cnt_q         <= '0;
            ptr_q         <= '0;
        end else begin
            up_done_q     <= 1'b0;
            child_start_q <= 1'b0;
            case (state_q)
                gomoku_pkg::NODE_IDLE: begin
                    if (i_down.start) begin
                        state_q <= gomoku_pkg::NODE_SCAN;
                        req_q   <= 1'b1;
                    end
                end
                gomoku_pkg::NODE_SCAN: begin
                    if (i_scan.done) begin
                        req_q <= 1'b0;
                        cnt_q <= i_scan.count;
                        ptr_q <= '0;
                        if (i_scan.win || i_last || i_scan.count == '0) begin
                            up_done_q <= 1'b1;
                            up_win_q  <= i_scan.win;
                            state_q   <= gomoku_pkg::NODE_IDLE;
                        end else begin
                            state_q <= gomoku_pkg::NODE_NEXT;
                        end
                    end
                end
                gomoku_pkg::NODE_NEXT: begin
                    if (place) begin
                        child_start_q <= 1'b1;
                        ptr_q         <= ptr_q + 3'd1;
                        state_q       <= gomoku_pkg::NODE_WAIT_CHILD;
                    end else begin
                        // every reply favoured the other side
                        up_done_q <= 1'b1;
                        up_win_q  <= 1'b0;
                        state_q   <= gomoku_pkg::NODE_IDLE;
                    end
                end
                gomoku_pkg::NODE_WAIT_CHILD: begin
                    if (i_child.done) begin
                        if (!i_child.win) begin
                            up_done_q <= 1'b1;
                            up_win_q  <= 1'b1;
                            state_q   <= gomoku_pkg::NODE_IDLE;
                        end else begin
                            state_q <= gomoku_pkg::NODE_NEXT;
                        end
                    end
                end
                default: state_q <= gomoku_pkg::NODE_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == gomoku_pkg::NODE_IDLE && i_down.start) begin
            board_q <= i_down.board;
        end
        if (state_q == gomoku_pkg::NODE_SCAN && i_scan.done) begin
            cand_q <= i_scan.cand;
        end
        if (place) begin
            child_board_q                         <= board_q;
            child_board_q[{cand_q[ptr_q], 1'b0} +: 2] <= stone;
        end
    end

    assign o_scan.valid  = req_q;
    assign o_scan.side   = i_side;
    assign o_scan.board  = board_q;
    assign o_child.start = child_start_q;
    assign o_child.board = child_board_q;
    assign o_up.done     = up_done_q;
    assign o_up.win      = up_win_q;

endmodule

// File: rtl/axil_regs.sv
// host register block
`timescale 1ns/1ps
module axil_regs (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  gomoku_pkg::axi_addr_t  i_awaddr,
    input  logic                   i_awvalid,
    output logic                   o_awready,
    input  gomoku_pkg::axi_data_t  i_wdata,
    input  logic                   i_wvalid,
    output logic                   o_wready,
    output logic                   o_bvalid,
    input  logic                   i_bready,
    input  gomoku_pkg::axi_addr_t  i_araddr,
    input  logic                   i_arvalid,
    output logic                   o_arready,
    output gomoku_pkg::axi_data_t  o_rdata,
    output logic                   o_rvalid,
    input  logic                   i_rready,
    output gomoku_pkg::node_down_t o_down,
    input  gomoku_pkg::node_up_t   i_up
);

    gomoku_pkg::row_t      row_q [gomoku_pkg::BOARD_N];
    logic                  busy_q;
    logic                  done_q;
    logic                  win_q;
    logic                  start_q;
    logic                  bvalid_q;
    logic                  rvalid_q;
    gomoku_pkg::axi_data_t rdata_q;
    gomoku_pkg::axi_addr_t wr_off;
    gomoku_pkg::axi_addr_t rd_off;
    gomoku_pkg::axi_data_t rd_word;
    logic                  wr_fire;
    logic                  rd_fire;

    assign wr_fire = i_awvalid & i_wvalid & ~bvalid_q;
    assign rd_fire = i_arvalid & ~rvalid_q;
    assign wr_off  = i_awaddr - gomoku_pkg::REG_ROW0;
    assign rd_off  = i_araddr - gomoku_pkg::REG_ROW0;

    always_comb begin
        rd_word = '0;
        if (rd_off < gomoku_pkg::REG_CTRL - gomoku_pkg::REG_ROW0) begin
            rd_word = gomoku_pkg::axi_data_t'(row_q[rd_off[5:2]]);
        end else if (i_araddr == gomoku_pkg::REG_STATUS) begin
            rd_word = {29'd0, win_q, done_q, busy_q};
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int r = 0; r < gomoku_pkg::BOARD_N; r++) begin
                row_q[r] <= '0;
            end
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
            win_q    <= 1'b0;
            start_q  <= 1'b0;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
            rdata_q  <= '0;
        end else begin
            start_q <= 1'b0;
            if (wr_fire) begin
                bvalid_q <= 1'b1;
                if (wr_off < gomoku_pkg::REG_CTRL - gomoku_pkg::REG_ROW0) begin
                    row_q[wr_off[5:2]] <= i_wdata[2*gomoku_pkg::BOARD_N-1:0];
                end else if (i_awaddr == gomoku_pkg::REG_CTRL && i_wdata[0] && !busy_q) begin
                    start_q <= 1'b1;
                    busy_q  <= 1'b1;
                    done_q  <= 1'b0;
                    win_q   <= 1'b0;
                end
            end else if (bvalid_q && i_bready) begin
                bvalid_q <= 1'b0;
            end
            // level 0 reports once per search
            if (busy_q && i_up.done) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
                win_q  <= i_up.win;
            end
            if (rd_fire) begin
                rvalid_q <= 1'b1;
                rdata_q  <= rd_word;
            end else if (rvalid_q && i_rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_comb begin
        o_down.start = start_q;
        for (int r = 0; r < gomoku_pkg::BOARD_N; r++) begin
            o_down.board[2*gomoku_pkg::BOARD_N*r +: 2*gomoku_pkg::BOARD_N] = row_q[r];
        end
    end

    assign o_awready = wr_fire;
    assign o_wready  = wr_fire;
    assign o_bvalid  = bvalid_q;
    assign o_arready = rd_fire;
    assign o_rvalid  = rvalid_q;
    assign o_rdata   = rdata_q;

endmodule

// File: rtl/kill_top.sv
// gomoku kill search top
`timescale 1ns/1ps
module kill_top (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  gomoku_pkg::axi_addr_t i_awaddr,
    input  logic                  i_awvalid,
    output logic                  o_awready,
    input  gomoku_pkg::axi_data_t i_wdata,
    input  logic                  i_wvalid,
    output logic                  o_wready,
    output logic                  o_bvalid,
    input  logic                  i_bready,
    input  gomoku_pkg::axi_addr_t i_araddr,
    input  logic                  i_arvalid,
    output logic                  o_arready,
    output gomoku_pkg::axi_data_t o_rdata,
    output logic                  o_rvalid,
    input  logic                  i_rready
);

    gomoku_pkg::node_down_t [gomoku_pkg::LEVELS:0]   down;
    gomoku_pkg::node_up_t   [gomoku_pkg::LEVELS:0]   up;
    gomoku_pkg::scan_req_t  [gomoku_pkg::LEVELS-1:0] lvl_req;
    gomoku_pkg::scan_rsp_t  [gomoku_pkg::LEVELS-1:0] lvl_rsp;
    gomoku_pkg::scan_req_t                           scan_req;
    gomoku_pkg::scan_rsp_t                           scan_rsp;

    // nothing below the last ply
    assign up[gomoku_pkg::LEVELS] = '0;

    axil_regs u_axil_regs (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_awaddr  (i_awaddr),
        .i_awvalid (i_awvalid),
        .o_awready (o_awready),
        .i_wdata   (i_wdata),
        .i_wvalid  (i_wvalid),
        .o_wready  (o_wready),
        .o_bvalid  (o_bvalid),
        .i_bready  (i_bready),
        .i_araddr  (i_araddr),
        .i_arvalid (i_arvalid),
        .o_arready (o_arready),
        .o_rdata   (o_rdata),
        .o_rvalid  (o_rvalid),
        .i_rready  (i_rready),
        .o_down    (down[0]),
        .i_up      (up[0])
    );

    for (genvar k = 0; k < gomoku_pkg::LEVELS; k++) begin : g_level
        // even levels are attacker plies
        kill_node u_kill_node (
            .i_clk   (i_clk),
            .i_rst_n (i_rst_n),
            .i_side  (k % 2 == 0),
            .i_last  (k == gomoku_pkg::LEVELS - 1),
            .i_down  (down[k]),
            .o_up    (up[k]),
            .o_child (down[k+1]),
            .i_child (up[k+1]),
            .o_scan  (lvl_req[k]),
            .i_scan  (lvl_rsp[k])
        );
    end

    scan_arbiter u_scan_arbiter (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_req      (lvl_req),
        .o_rsp      (lvl_rsp),
        .o_scan_req (scan_req),
        .i_scan_rsp (scan_rsp)
    );

    threat_scan u_threat_scan (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (scan_req),
        .o_rsp   (scan_rsp)
    );

endmodule

// File: verif/kill_cases.svh
// kill search test positions
`ifndef KILL_CASES_SVH
`define KILL_CASES_SVH

// entry columns as hex nibbles: color, row, col (color 1 black, 2 white)
// an entry 'hF0w closes a case and w is the expected win
localparam int N_CASES   = 7;
localparam int N_ENTRIES = 50;

// neutral corner for filler, 2x2 so no color can reach a four
localparam int FILL_ROW0 = 13;
localparam int FILL_COL0 = 13;
localparam int FILL_SPAN = 2;

logic [11:0] case_tab [N_ENTRIES] = '{
    // open four in row 7, black completes at once
    12'h173, 12'h174, 12'h175, 12'h176, 12'hF01,
    // closed four at (3,5) also opens a three in column 5
    12'h231, 12'h132, 12'h133, 12'h134, 12'h145, 12'h155, 12'hF01,
    // white blocks at (8,6) and completes its own column
    12'h281, 12'h182, 12'h183, 12'h184,
    12'h246, 12'h256, 12'h266, 12'h276, 12'h136, 12'hF00,
    // lone closed three, nothing after the block
    12'h218, 12'h119, 12'h11A, 12'h11B, 12'hF00,
    // four attacker moves needed: (3,5), (4,5), then open four in row 4
    12'h231, 12'h132, 12'h133, 12'h134,
    12'h205, 12'h115, 12'h125, 12'h146, 12'h147, 12'hF00,
    // same chain with the first exchange already played
    12'h231, 12'h132, 12'h133, 12'h134, 12'h135, 12'h236,
    12'h205, 12'h115, 12'h125, 12'h146, 12'h147, 12'hF01,
    // empty board apart from filler
    12'hF00
};

`endif

// File: verif/kill_tb.sv
// kill search testbench
`timescale 1ns/1ps
module kill_tb;

    `include "kill_cases.svh"

    // every node of a full 5-ply tree, each one scan long
    localparam int WATCHDOG_NS  = N_CASES * 341 * 230 * 4 + 50_000;
    localparam int QUIET_CYCLES = 2 * 226;

    logic                  clk;
    logic                  rst_n;
    gomoku_pkg::axi_addr_t awaddr;
    logic                  awvalid;
    logic                  awready;
    gomoku_pkg::axi_data_t wdata;
    logic                  wvalid;
    logic                  wready;
    logic                  bvalid;
    logic                  bready;
    gomoku_pkg::axi_addr_t araddr;
    logic                  arvalid;
    logic                  arready;
    gomoku_pkg::axi_data_t rdata;
    logic                  rvalid;
    logic                  rready;

    gomoku_pkg::row_t      rows [gomoku_pkg::BOARD_N];
    gomoku_pkg::axi_data_t row_word [gomoku_pkg::BOARD_N];
    logic [31:0]           seed;
    int                    errors;
    int                    checks;

    kill_top u_kill_top (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_awaddr  (awaddr),
        .i_awvalid (awvalid),
        .o_awready (awready),
        .i_wdata   (wdata),
        .i_wvalid  (wvalid),
        .o_wready  (wready),
        .o_bvalid  (bvalid),
        .i_bready  (bready),
        .i_araddr  (araddr),
        .i_arvalid (arvalid),
        .o_arready (arready),
        .o_rdata   (rdata),
        .o_rvalid  (rvalid),
        .i_rready  (rready)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input gomoku_pkg::axi_addr_t addr, input gomoku_pkg::axi_data_t data);
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        do begin
            @(posedge clk);
        end while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do begin
            @(posedge clk);
        end while (!bvalid);
        bready <= 1'b0;
    endtask

    task automatic read_reg(input gomoku_pkg::axi_addr_t addr, output gomoku_pkg::axi_data_t data);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        do begin
            @(posedge clk);
        end while (!arready);
        arvalid <= 1'b0;
        do begin
            @(posedge clk);
        end while (!rvalid);
        data = rdata;
        rready <= 1'b0;
    endtask

    task automatic wait_done(output gomoku_pkg::axi_data_t status);
        status = '0;
        while (!status[1]) begin
            read_reg(gomoku_pkg::REG_STATUS, status);
        end
    endtask

    // builds one position from the table and writes all rows
    task automatic load_board(input int first, output int next, output logic exp_win);
        int          k;
        logic [11:0] e;
        for (int r = 0; r < gomoku_pkg::BOARD_N; r++) begin
            rows[r] = '0;
        end
        for (int r = FILL_ROW0; r < FILL_ROW0 + FILL_SPAN; r++) begin
            for (int c = FILL_COL0; c < FILL_COL0 + FILL_SPAN; c++) begin
                seed = xorshift(seed);
                rows[r][2*c +: 2] = 2'(seed % 3);
            end
        end
        k = first;
        while (case_tab[k][11:8] != 4'hF) begin
            e = case_tab[k];
            rows[e[7:4]][2*e[3:0] +: 2] = e[9:8];
            k++;
        end
        exp_win = case_tab[k][0];
        next    = k + 1;
        for (int r = 0; r < gomoku_pkg::BOARD_N; r++) begin
            write_reg(gomoku_pkg::axi_addr_t'(gomoku_pkg::REG_ROW0 + 4 * r), {2'b00, rows[r]});
        end
    endtask

    initial begin
        gomoku_pkg::axi_data_t rd;
        logic [31:0]           result;
        logic                  exp_win;
        int                    ptr;
        clk     = 1'b0;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        seed    = 32'ha430_55bb;
        errors  = 0;
        checks  = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        read_reg(gomoku_pkg::REG_STATUS, rd);
        compare(rd, 32'h0, "status after reset");
        for (int r = 0; r < gomoku_pkg::BOARD_N; r++) begin
            seed        = xorshift(seed);
            row_word[r] = seed;
            write_reg(gomoku_pkg::axi_addr_t'(gomoku_pkg::REG_ROW0 + 4 * r), row_word[r]);
        end
        // only 15 cells of 2 bits are kept per row
        for (int r = 0; r < gomoku_pkg::BOARD_N; r++) begin
            read_reg(gomoku_pkg::axi_addr_t'(gomoku_pkg::REG_ROW0 + 4 * r), rd);
            compare(rd, row_word[r] & 32'h3FFF_FFFF, $sformatf("row %0d readback", r));
        end
        read_reg(7'h44, rd);
        compare(rd, 32'h0, "unmapped read at 0x44");
        read_reg(7'h7C, rd);
        compare(rd, 32'h0, "unmapped read at 0x7c");

        ptr = 0;
        for (int i = 0; i < N_CASES; i++) begin
            load_board(ptr, ptr, exp_win);
            result = {29'd0, exp_win, 2'b10};
            write_reg(gomoku_pkg::REG_CTRL, 32'h1);
            read_reg(gomoku_pkg::REG_STATUS, rd);
            compare(rd, 32'h1, $sformatf("case %0d busy after start", i));
            // a scan alone outlasts this second start
            write_reg(gomoku_pkg::REG_CTRL, 32'h1);
            read_reg(gomoku_pkg::REG_STATUS, rd);
            compare(rd, 32'h1, $sformatf("case %0d status after start while busy", i));
            wait_done(rd);
            compare(rd, result, $sformatf("case %0d search result", i));
            repeat (QUIET_CYCLES) @(posedge clk);
            read_reg(gomoku_pkg::REG_STATUS, rd);
            compare(rd, result, $sformatf("case %0d status held after done", i));
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the search never finished within %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: files.f
+incdir+verif
rtl/gomoku_pkg.sv
rtl/threat_scan.sv
rtl/scan_arbiter.sv
rtl/kill_node.sv
rtl/axil_regs.sv
rtl/kill_top.sv
verif/kill_tb.sv
